/* hw/cpu_defs.svh */
// ==============================
// Sizing macros for the SAP-1 style CPU
// CPU_ADDR_W must address all CPU_RAM_BYTES words
// CPU_T_STATES is fixed by the control ring; do not change alone
// ==============================
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_DATA_W    8   // Bus and register width
`define CPU_ADDR_W    4   // RAM address and PC width
`define CPU_RAM_BYTES 16  // Program plus data space
`define CPU_T_STATES  6   // Cycles per executed instruction

`endif

/* hw/cpu_pkg.sv */
// ==============================
// Shared types for the CPU
// Control word order follows the original strobe layout
// Active-low strobes are named n_*
// ==============================
`include "cpu_defs.svh"

package cpu_pkg;

    localparam int RAM_BYTES = `CPU_RAM_BYTES;
    localparam int T_STATES  = `CPU_T_STATES;

    typedef logic [`CPU_DATA_W-1:0] data_t;  // One bus byte
    typedef logic [`CPU_ADDR_W-1:0] addr_t;  // RAM address or PC value

    // High nibble of an instruction byte; other codes act as no-ops
    typedef enum logic [3:0] {
        LDA = 4'h0,
        ADD = 4'h1,
        SUB = 4'h2,
        OUT = 4'hE,
        HLT = 4'hF
    } opcode_e;

    typedef struct packed {
        logic cp;     // PC count
        logic ep;     // PC onto bus
        logic n_lma;  // Load MAR address
        logic n_lmd;  // Load RAM data register
        logic n_ce;   // RAM onto bus
        logic n_lr;   // RAM write
        logic n_li;   // Load IR
        logic n_ei;   // IR low nibble onto bus
        logic n_la;   // Load accumulator
        logic ea;     // Accumulator onto bus
        logic sub;    // ALU subtracts
        logic eu;     // ALU onto bus
        logic n_lb;   // Load B
        logic n_lo;   // Load output register
    } ctrl_word_t;

    // Nothing enabled, active-low strobes parked high
    localparam ctrl_word_t CTRL_IDLE = '{
        cp: 1'b0, ep: 1'b0, n_lma: 1'b1, n_lmd: 1'b1, n_ce: 1'b1,
        n_lr: 1'b1, n_li: 1'b1, n_ei: 1'b1, n_la: 1'b1, ea: 1'b0,
        sub: 1'b0, eu: 1'b0, n_lb: 1'b1, n_lo: 1'b1
    };

endpackage

/* hw/control_block.sv */
// ==============================
// Loader sequencer and T-state controller
// Loader ignores ui_in validity; the host must follow ready_for_ui
// Loading runs once per reset, 4 cycles per byte
// HLT stops the ring until the next reset
// ==============================
module control_block
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       programming,   // Host wants to load RAM
    input  opcode_e    opcode,        // From IR, valid from T3 on
    output ctrl_word_t ctrl,
    output logic       read_ui_in,    // ui_in drives the bus
    output logic       ready_for_ui,  // Host byte is sampled this cycle
    output logic       done_load,
    output logic       halted
);

    localparam logic [3:0]          L_FIRST = 4'b0001;
    localparam logic [T_STATES-1:0] T_FIRST = T_STATES'(1);

    logic [3:0]          l_ring;    // One-hot L1..L4
    logic [T_STATES-1:0] t_ring;    // One-hot T1..T6
    addr_t               byte_cnt;  // Bytes loaded so far
    logic                armed;     // Low for the first cycle after reset
    logic                loading;
    logic                running;

    assign loading = armed & programming & ~done_load;
    assign running = done_load & ~programming & ~halted;  // done_load implies armed

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            armed     <= 1'b0;
            l_ring    <= L_FIRST;
            t_ring    <= T_FIRST;
            byte_cnt  <= '0;
            done_load <= 1'b0;
            halted    <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (loading) begin
                l_ring <= {l_ring[2:0], l_ring[3]};  // Rotate L1 -> L4
                if (l_ring[3]) begin
                    byte_cnt <= byte_cnt + 1'b1;
                    // Last slot written, PC wraps to 0 on this same edge
                    if (byte_cnt == addr_t'(RAM_BYTES - 1))
                        done_load <= 1'b1;
                end
            end
            if (running) begin
                t_ring <= {t_ring[T_STATES-2:0], t_ring[T_STATES-1]};
                if (t_ring[2] && opcode == HLT)
                    halted <= 1'b1;  // Freezes the ring from the next cycle
            end
        end
    end

    // Strobe decode from ring state and opcode
    always_comb begin
        ctrl         = CTRL_IDLE;
        read_ui_in   = 1'b0;
        ready_for_ui = 1'b0;
        if (loading) begin
            if (l_ring[0]) begin       // L1: PC to MAR
                ctrl.ep    = 1'b1;
                ctrl.n_lma = 1'b0;
            end
            if (l_ring[1]) begin       // L2: host byte into data reg
                read_ui_in   = 1'b1;
                ready_for_ui = 1'b1;
                ctrl.n_lmd   = 1'b0;
            end
            if (l_ring[2])             // L3: commit to RAM
                ctrl.n_lr = 1'b0;
            if (l_ring[3])             // L4: next slot
                ctrl.cp = 1'b1;
        end else if (running) begin
            if (t_ring[0]) begin       // T1: fetch address
                ctrl.ep    = 1'b1;
                ctrl.n_lma = 1'b0;
            end
            if (t_ring[1]) begin       // T2: fetch byte, bump PC
                ctrl.n_ce = 1'b0;
                ctrl.n_li = 1'b0;
                ctrl.cp   = 1'b1;
            end
            if (t_ring[2]) begin
                case (opcode)
                    LDA, ADD, SUB: begin   // Operand address to MAR
                        ctrl.n_ei  = 1'b0;
                        ctrl.n_lma = 1'b0;
                    end
                    OUT: begin
                        ctrl.ea   = 1'b1;
                        ctrl.n_lo = 1'b0;
                    end
                    default: ;             // HLT handled in the ring, rest no-op
                endcase
            end
            if (t_ring[3]) begin
                case (opcode)
                    LDA: begin
                        ctrl.n_ce = 1'b0;
                        ctrl.n_la = 1'b0;
                    end
                    ADD, SUB: begin        // Operand into B
                        ctrl.n_ce = 1'b0;
                        ctrl.n_lb = 1'b0;
                    end
                    default: ;
                endcase
            end
            if (t_ring[4] && (opcode == ADD || opcode == SUB)) begin
                ctrl.eu   = 1'b1;
                ctrl.sub  = (opcode == SUB);
                ctrl.n_la = 1'b0;          // Result back into A
            end
            // T6 is idle
        end
    end

endmodule

/* hw/memory_unit.sv */
// ==============================
// PC, MAR, RAM data register and RAM
// RAM keeps its contents over reset
// Reads are combinational from the MAR
// ==============================
module memory_unit
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_word_t ctrl,
    input  data_t      bus,
    output data_t      pc_bus,   // PC, zero-extended
    output data_t      ram_bus   // Byte at the MAR address
);

    addr_t pc;
    addr_t mar_addr;
    data_t mdr;                  // Staged write data
    data_t ram [RAM_BYTES];

    // Program counter, wraps at 16
    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= '0;
        else if (ctrl.cp)
            pc <= pc + 1'b1;
    end

    // Address and data staging
    always_ff @(posedge clk) begin
        if (!ctrl.n_lma)
            mar_addr <= bus[$bits(addr_t)-1:0];  // Low nibble only
        if (!ctrl.n_lmd)
            mdr <= bus;
    end

    // Write port
    always_ff @(posedge clk) begin
        if (!ctrl.n_lr)
            ram[mar_addr] <= mdr;
    end

    assign pc_bus  = data_t'(pc);
    assign ram_bus = ram[mar_addr];  // Top level decides if it reaches the bus

endmodule

/* hw/register_bank.sv */
// ==============================
// A, B, IR and output registers plus ALU
// ALU result wraps modulo 256, no flags
// ==============================
module register_bank
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_word_t ctrl,
    input  data_t      bus,
    output opcode_e    opcode,     // IR high nibble
    output data_t      ir_bus,     // IR low nibble, zero-extended
    output data_t      acc_bus,
    output data_t      alu_bus,
    output data_t      out_value   // Output register
);

    data_t acc;
    data_t b_reg;
    data_t ir;
    data_t out_reg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc     <= '0;
            b_reg   <= '0;
            ir      <= '0;
            out_reg <= '0;
        end else begin
            if (!ctrl.n_la)
                acc <= bus;
            if (!ctrl.n_lb)
                b_reg <= bus;
            if (!ctrl.n_li)
                ir <= bus;
            if (!ctrl.n_lo)
                out_reg <= bus;   // Only OUT writes this
        end
    end

    // Adder-subtractor, carry dropped
    assign alu_bus = ctrl.sub ? (acc - b_reg) : (acc + b_reg);

    // Unknown codes pass through, control block treats them as no-ops
    assign opcode    = opcode_e'(ir[$bits(data_t)-1:$bits(addr_t)]);
    assign ir_bus    = data_t'(ir[$bits(addr_t)-1:0]);
    assign acc_bus   = acc;
    assign out_value = out_reg;

endmodule

/* hw/cpu_top.sv */
// ==============================
// SAP-1 style CPU top level
// uio_in[0] selects program load
// uio_out[3:1] are halted, done_load, ready_for_ui
// ena and uio_in[7:1] are not used
// ==============================
module cpu_top
    import cpu_pkg::*;
(
    input  data_t ui_in,    // Program bytes while loading
    output data_t uo_out,   // Output register
    input  data_t uio_in,
    output data_t uio_out,
    output data_t uio_oe,
    input  logic  ena,
    input  logic  clk,
    input  logic  rst_n
);

    ctrl_word_t ctrl;
    data_t      bus;
    data_t      pc_bus;
    data_t      ram_bus;
    data_t      ir_bus;
    data_t      acc_bus;
    data_t      alu_bus;
    opcode_e    opcode;
    logic       read_ui_in;
    logic       ready_for_ui;
    logic       done_load;
    logic       halted;

    // Shared bus, one source per cycle by construction
    always_comb begin
        if (read_ui_in)
            bus = ui_in;
        else if (ctrl.ep)
            bus = pc_bus;
        else if (!ctrl.n_ce)
            bus = ram_bus;
        else if (!ctrl.n_ei)
            bus = ir_bus;
        else if (ctrl.ea)
            bus = acc_bus;
        else if (ctrl.eu)
            bus = alu_bus;
        else
            bus = '0;  // Idle bus reads as zero
    end

    control_block u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .programming  (uio_in[0]),
        .opcode       (opcode),
        .ctrl         (ctrl),
        .read_ui_in   (read_ui_in),
        .ready_for_ui (ready_for_ui),
        .done_load    (done_load),
        .halted       (halted)
    );

    memory_unit u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .bus     (bus),
        .pc_bus  (pc_bus),
        .ram_bus (ram_bus)
    );

    register_bank u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .bus       (bus),
        .opcode    (opcode),
        .ir_bus    (ir_bus),
        .acc_bus   (acc_bus),
        .alu_bus   (alu_bus),
        .out_value (uo_out)
    );

    // Status bits out, bit 0 stays an input
    assign uio_out = {4'b0000, halted, done_load, ready_for_ui, 1'b0};
    assign uio_oe  = 8'b0000_1110;

endmodule

/* tests/tb_cpu_top.sv */
// ==============================
// Directed testbench for the SAP-1 style CPU
// Inputs change on the falling edge, outputs are sampled there too
// An OUT is seen only as a change of uo_out, so random operands
// are nudged away from zero and repeated results
// ==============================
`include "cpu_defs.svh"

module tb_cpu_top
    import cpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF   = 50;
    localparam int T          = `CPU_T_STATES;
    localparam int LOAD_LIMIT = `CPU_RAM_BYTES * 4 + 10;
    // Six loads of about 70 cycles, about 40 instructions, 50 hold cycles, margin
    localparam int MAX_CYCLES = 2000;

    logic  clk;
    logic  rst_n;
    data_t ui_in;
    data_t uio_in;
    logic  ena;
    data_t uo_out;
    data_t uio_out;
    data_t uio_oe;
    logic  ready_for_ui;
    logic  done_load;
    logic  halted;

    int    cycle_count = 0;
    int    error_count;               // Wrong values
    int    fail_count;                // Waits that ran out
    int    seed;
    data_t prog [`CPU_RAM_BYTES];     // Image handed to the loader
    data_t out_log [$];               // uo_out changes of the last run

    assign ready_for_ui = uio_out[1];
    assign done_load    = uio_out[2];
    assign halted       = uio_out[3];

    cpu_top u_dut (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n  = 1'b0;
        uio_in = '0;
        ui_in  = '0;
        repeat (3) @(negedge clk);   // Three rising edges with rst_n low
        rst_n = 1'b1;
    endtask

    function automatic data_t make_instr(input opcode_e op, input addr_t addr);
        return {op, addr};
    endfunction

    task automatic clear_program();
        foreach (prog[i])
            prog[i] = '0;
    endtask

    // Follows ready_for_ui, one byte per pulse
    task automatic load_program(input data_t bytes [`CPU_RAM_BYTES]);
        int sent;
        int waited;
        int last_pulse;
        sent       = 0;
        waited     = 0;
        last_pulse = 0;
        @(negedge clk);
        uio_in[0] = 1'b1;
        while (!done_load && waited < LOAD_LIMIT) begin
            @(negedge clk);
            waited++;
            if (ready_for_ui) begin
                if (sent > 0)
                    check_data(data_t'(cycle_count - last_pulse), 8'd4, "ready_for_ui spacing");
                last_pulse = cycle_count;
                if (sent < `CPU_RAM_BYTES)
                    ui_in = bytes[sent];
                sent++;
            end
        end
        if (!done_load) begin
            fail_count++;
            $display("Loader did not raise done_load within %0d cycles", LOAD_LIMIT);
        end
        check_data(data_t'(sent), data_t'(`CPU_RAM_BYTES), "ready_for_ui pulse count");
        uio_in[0] = 1'b0;            // Execution starts from here
        ui_in     = '0;
    endtask

    // Logs every uo_out change until halted
    task automatic run_until_halt(input int limit);
        int    waited;
        data_t last;
        waited = 0;
        last   = uo_out;
        out_log.delete();
        while (!halted && waited < limit) begin
            @(negedge clk);
            waited++;
            if (uo_out !== last) begin
                out_log.push_back(uo_out);
                last = uo_out;
            end
            check_bit(done_load, 1'b1, "done_load while running");
        end
        if (!halted) begin
            fail_count++;
            $display("CPU did not halt within %0d cycles", limit);
        end
    endtask

    task automatic hold_after_halt(input int cycles);
        data_t held;
        held = uo_out;
        repeat (cycles) begin
            @(negedge clk);
            check_data(uo_out, held, "uo_out after halt");
            check_bit(halted, 1'b1, "halted level");
            check_bit(done_load, 1'b1, "done_load level");
        end
    endtask

    task automatic test_reset_state();
        check_data(uo_out, '0, "uo_out after reset");
        check_bit(ready_for_ui, 1'b0, "ready_for_ui after reset");
        check_bit(done_load, 1'b0, "done_load after reset");
        check_bit(halted, 1'b0, "halted after reset");
        check_data(uio_out & 8'hF1, '0, "unused uio_out bits");
        check_data(uio_oe, 8'h0E, "uio_oe");
    endtask

    // LDA 14, OUT, HLT followed by an LDA 13, OUT that must never run
    task automatic test_load_and_output();
        data_t value;
        value = data_t'($random(seed));
        if (value == '0)
            value = 8'h5A;
        apply_reset();
        clear_program();
        prog[0]  = make_instr(LDA, 4'd14);
        prog[1]  = make_instr(OUT, 4'd0);
        prog[2]  = make_instr(HLT, 4'd0);
        prog[3]  = make_instr(LDA, 4'd13);
        prog[4]  = make_instr(OUT, 4'd0);
        prog[13] = ~value;            // A run past HLT would show up on uo_out
        prog[14] = value;
        load_program(prog);
        check_bit(done_load, 1'b1, "done_load after load");
        run_until_halt(4 * T);
        check_data(data_t'(out_log.size()), 8'd1, "OUT count");
        if (out_log.size() > 0)
            check_data(out_log[0], value, "LDA then OUT");
        check_bit(halted, 1'b1, "halted after HLT");
        hold_after_halt(50);
    endtask

    // LDA a, ADD b, OUT, SUB c, OUT, HLT
    task automatic test_arithmetic(input int rounds);
        data_t a;
        data_t b;
        data_t c;
        data_t sum;
        data_t diff;
        repeat (rounds) begin
            a   = data_t'($random(seed));
            b   = data_t'($random(seed));
            c   = data_t'($random(seed));
            sum = a + b;                 // Wraps at 256
            if (sum == '0) begin
                b   = b + 8'd1;
                sum = a + b;
            end
            if (c == '0)
                c = 8'd1;
            diff = sum - c;
            apply_reset();
            clear_program();
            prog[0]  = make_instr(LDA, 4'd13);
            prog[1]  = make_instr(ADD, 4'd14);
            prog[2]  = make_instr(OUT, 4'd0);
            prog[3]  = make_instr(SUB, 4'd15);
            prog[4]  = make_instr(OUT, 4'd0);
            prog[5]  = make_instr(HLT, 4'd0);
            prog[13] = a;
            prog[14] = b;
            prog[15] = c;
            load_program(prog);
            run_until_halt(7 * T);
            check_data(data_t'(out_log.size()), 8'd2, "OUT count");
            if (out_log.size() >= 2) begin
                check_data(out_log[0], sum, "a+b");
                check_data(out_log[1], diff, "a+b-c");
            end
        end
    endtask

    // Reset after a halt, then a new program
    task automatic test_reload();
        data_t exp;
        apply_reset();
        check_data(uo_out, '0, "uo_out after second reset");
        check_bit(halted, 1'b0, "halted after second reset");
        check_bit(done_load, 1'b0, "done_load after second reset");
        clear_program();
        prog[0]  = make_instr(LDA, 4'd15);
        prog[1]  = make_instr(SUB, 4'd14);
        prog[2]  = make_instr(OUT, 4'd0);
        prog[3]  = make_instr(HLT, 4'd0);
        prog[14] = 8'h11;
        prog[15] = 8'h05;
        exp      = prog[15] - prog[14];  // Borrows through zero
        load_program(prog);
        run_until_halt(5 * T);
        check_data(data_t'(out_log.size()), 8'd1, "OUT count after reload");
        if (out_log.size() > 0)
            check_data(out_log[0], exp, "reloaded program result");
    endtask

    initial begin
        rst_n       = 1'b0;
        ui_in       = '0;
        uio_in      = '0;
        ena         = 1'b1;
        error_count = 0;
        fail_count  = 0;
        seed        = 32'ha5d3eb47;
        apply_reset();
        test_reset_state();
        test_load_and_output();
        test_arithmetic(4);
        test_reload();
        $display("Finished: %0d wrong values, %0d other failures", error_count, fail_count);
        if (error_count == 0 && fail_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
hw/cpu_pkg.sv
hw/control_block.sv
hw/memory_unit.sv
hw/register_bank.sv
hw/cpu_top.sv
tests/tb_cpu_top.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps
TOP       = tb_cpu_top
FILE_LIST = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
